//--- project.f
hdl/fb_cfg_pkg.sv
hdl/fb_types_pkg.sv
hdl/dp_pipe_ram.sv
hdl/frame_writer.sv
hdl/word_counter.sv
hdl/drain_fsm.sv
hdl/frame_buffer_top.sv
dv/frame_buffer_checker.sv
dv/frame_buffer_tb.sv

//--- Bender.yml
package:
  name: frame_buffer

sources:
  # packages first, then the design bottom-up
  - hdl/fb_cfg_pkg.sv
  - hdl/fb_types_pkg.sv
  - hdl/dp_pipe_ram.sv
  - hdl/frame_writer.sv
  - hdl/word_counter.sv
  - hdl/drain_fsm.sv
  - hdl/frame_buffer_top.sv
  - target: test
    files:
      - dv/frame_buffer_checker.sv
      - dv/frame_buffer_tb.sv

//--- dv/frame_patterns.txt
# name idle drain_en in_length first_word(hex) accept out_length trunc pending(hex)
# pending is frames_pending two cycles after the last input word, f means not checked
single5  6  1 5  1000 1 5  0 f
trunc40  3  1 40 2000 1 32 1 f
exact32  3  1 32 3000 1 32 0 f
cut33    3  1 33 4000 1 32 1 f
b2b_a    0  1 7  5000 1 7  0 f
b2b_b    0  1 1  5100 1 1  0 f
b2b_c    0  1 12 5200 1 12 0 f
b2b_wrap 0  1 3  fffe 1 3  0 f
# draining paused, eight frames fill every slot
fill0    2  0 4  6000 1 4  0 1
fill1    0  0 6  6100 1 6  0 2
fill2    0  0 2  6200 1 2  0 3
fill3    0  0 9  6300 1 9  0 4
fill4    0  0 1  6400 1 1  0 5
fill5    0  0 40 6500 1 32 1 6
fill6    0  0 5  6600 1 5  0 7
fill7    0  0 3  6700 1 3  0 8
# ninth frame finds no free slot
drop8    2  0 3  7000 0 0  0 8
# draining resumes, the stored frames leave before this one
release  40 1 2  8000 1 2  0 f

//--- dv/frame_buffer_tb.sv
// testbench for frame_buffer_top; replays dv/frame_patterns.txt and checks every output frame
`timescale 1ns/100ps

module frame_buffer_tb;

    localparam int MAX_TESTS = 64;
    localparam int PW = fb_cfg_pkg::SLOT_W + 1;
    localparam logic [PW-1:0] NO_CHECK = '1;

    logic                     clk_a;
    logic                     rst_n;
    logic                     drain_en;
    fb_types_pkg::in_beat_t   in_beat;
    fb_types_pkg::out_beat_t  out_beat;
    logic [PW-1:0]            frames_pending;
    logic                     frame_dropped;

    // one entry per pattern line
    string                    names [MAX_TESTS];
    int                       gap [MAX_TESTS];
    logic                     drain [MAX_TESTS];
    int                       in_len [MAX_TESTS];
    fb_types_pkg::data_word_t first_w [MAX_TESTS];
    logic                     accept [MAX_TESTS];
    int                       exp_len [MAX_TESTS];
    logic                     exp_trunc [MAX_TESTS];
    logic [PW-1:0]            exp_pend [MAX_TESTS];
    logic                     test_bad [MAX_TESTS];

    int n_tests;
    int err_cnt;
    int pass_cnt;
    int fail_cnt;
    int drop_cnt;
    int wd_cycles;
    // indices of accepted tests still waiting for their output frame
    int exp_q [$];
    fb_types_pkg::out_beat_t got_q [$];

    initial begin
        clk_a = 1'b0;
        forever #2 clk_a = ~clk_a;
    end

    frame_buffer_top UUT (
        .clk_a         (clk_a),
        .rst_n         (rst_n),
        .in_beat       (in_beat),
        .drain_en      (drain_en),
        .out_beat      (out_beat),
        .frames_pending(frames_pending),
        .frame_dropped (frame_dropped)
    );

    task automatic check_word(input int idx, input string what,
                              input fb_types_pkg::data_word_t exp,
                              input fb_types_pkg::data_word_t got);
        if (got !== exp) begin
            $display("CHECK FAILED %s %s: expected %h, got %h", names[idx], what, exp, got);
            test_bad[idx] = 1'b1;
            err_cnt++;
        end
    endtask

    task automatic check_beat_flags(input int idx, input string what,
                                    input fb_types_pkg::out_beat_t exp,
                                    input fb_types_pkg::out_beat_t got);
        if ({got.valid, got.last, got.trunc} !== {exp.valid, exp.last, exp.trunc}) begin
            $display("CHECK FAILED %s %s: expected valid/last/trunc %b%b%b, got %b%b%b",
                     names[idx], what, exp.valid, exp.last, exp.trunc,
                     got.valid, got.last, got.trunc);
            test_bad[idx] = 1'b1;
            err_cnt++;
        end
    endtask

    task automatic check_count(input int idx, input string what,
                               input logic [PW-1:0] exp, input logic [PW-1:0] got);
        if (got !== exp) begin
            $display("CHECK FAILED %s %s: expected %0d, got %0d", names[idx], what, exp, got);
            test_bad[idx] = 1'b1;
            err_cnt++;
        end
    endtask

    task automatic finish_test(input int idx);
        if (test_bad[idx]) begin
            fail_cnt++;
            $display("test %-8s failed", names[idx]);
        end else begin
            pass_cnt++;
            $display("test %-8s passed", names[idx]);
        end
    endtask

    // expected words follow from the first word and the stored length
    task automatic compare_frame();
        int idx;
        fb_types_pkg::out_beat_t want;
        if (exp_q.size() == 0) begin
            $display("an output frame of %0d words arrived with no frame expected", got_q.size());
            err_cnt++;
        end else begin
            idx = exp_q.pop_front();
            if (got_q.size() != exp_len[idx]) begin
                $display("CHECK FAILED %s frame length: expected %0d, got %0d",
                         names[idx], exp_len[idx], got_q.size());
                test_bad[idx] = 1'b1;
                err_cnt++;
            end
            foreach (got_q[i]) begin
                want.valid = 1'b1;
                want.last = (i == exp_len[idx] - 1);
                want.trunc = want.last && exp_trunc[idx];
                want.data = first_w[idx] + fb_types_pkg::data_word_t'(i);
                check_word(idx, $sformatf("word %0d", i), want.data, got_q[i].data);
                check_beat_flags(idx, $sformatf("flags %0d", i), want, got_q[i]);
            end
            finish_test(idx);
        end
        got_q.delete();
    endtask

    task automatic load_patterns();
        int fd;
        int idle;
        int drn;
        int len;
        int acc;
        int olen;
        int trn;
        int total;
        logic [15:0] first;
        logic [PW-1:0] pend;
        string nm;
        string line;
        total = 20;
        fd = $fopen("dv/frame_patterns.txt", "r");
        if (fd == 0) begin
            $display("could not open dv/frame_patterns.txt");
        end else begin
            while (!$feof(fd) && n_tests < MAX_TESTS) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line[0] != "#") begin
                    if ($sscanf(line, "%s %d %d %d %h %d %d %d %h", nm, idle, drn, len,
                                first, acc, olen, trn, pend) == 9) begin
                        names[n_tests] = nm;
                        gap[n_tests] = idle;
                        drain[n_tests] = (drn != 0);
                        in_len[n_tests] = len;
                        first_w[n_tests] = first;
                        accept[n_tests] = (acc != 0);
                        exp_len[n_tests] = olen;
                        exp_trunc[n_tests] = (trn != 0);
                        exp_pend[n_tests] = pend;
                        test_bad[n_tests] = 1'b0;
                        total += 2 * (idle + 3 + len + 2) + 40;
                        n_tests++;
                    end
                end
            end
            $fclose(fd);
        end
        wd_cycles = total;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(negedge clk_a);
            in_beat = '0;
        end
    endtask

    task automatic wait_drained();
        while (frames_pending != '0 || exp_q.size() != 0) begin
            @(negedge clk_a);
            in_beat = '0;
        end
    endtask

    // outputs stay quiet between reset and the first commit
    task automatic watch_reset_quiet();
        repeat (4) begin
            @(negedge clk_a);
            check_beat_flags(0, "after reset", '0, out_beat);
            check_count(0, "frames_pending after reset", '0, frames_pending);
            check_count(0, "frame_dropped after reset", '0, PW'(frame_dropped));
        end
    endtask

    // commit registers, then frames_pending follows one cycle later
    task automatic check_frame_status(input int idx, input int drops_before);
        repeat (2) @(negedge clk_a);
        check_count(idx, "drop pulses", accept[idx] ? PW'(0) : PW'(1),
                    PW'(drop_cnt - drops_before));
        if (exp_pend[idx] != NO_CHECK) begin
            check_count(idx, "frames_pending", exp_pend[idx], frames_pending);
        end
        if (!accept[idx]) begin
            finish_test(idx);
        end
    endtask

    task automatic drive_test(input int idx);
        int extra;
        int drops_before;
        extra = $urandom % 4;
        // earlier frames leave before draining pauses
        if (!drain[idx] && drain_en) begin
            wait_drained();
        end
        drain_en = drain[idx];
        idle_cycles(gap[idx] + extra);
        drops_before = drop_cnt;
        if (accept[idx]) begin
            exp_q.push_back(idx);
        end
        for (int i = 0; i < in_len[idx]; i++) begin
            @(negedge clk_a);
            in_beat.valid = 1'b1;
            in_beat.last = (i == in_len[idx] - 1);
            in_beat.data = first_w[idx] + fb_types_pkg::data_word_t'(i);
        end
        // status checks run while the next frame goes in
        fork
            check_frame_status(idx, drops_before);
        join_none
    endtask

    // sampled on the falling edge half a cycle after the outputs move
    initial begin : monitor
        fb_types_pkg::out_beat_t beat;
        forever begin
            @(negedge clk_a);
            if (frame_dropped === 1'b1) begin
                drop_cnt++;
            end
            beat = out_beat;
            if (beat.valid === 1'b1) begin
                got_q.push_back(beat);
                if (beat.last === 1'b1 || got_q.size() == fb_cfg_pkg::SLOT_WORDS) begin
                    compare_frame();
                end
            end else if (got_q.size() != 0) begin
                $display("an output frame stopped before its last word");
                err_cnt++;
                compare_frame();
            end
        end
    end

    initial begin : watchdog
        wait (wd_cycles > 0);
        repeat (wd_cycles) @(posedge clk_a);
        $display("timeout: run did not finish within %0d cycles", wd_cycles);
        $display("TEST FAILED");
        $finish;
    end

    initial begin : main
        rst_n = 1'b0;
        drain_en = 1'b0;
        in_beat = '0;
        n_tests = 0;
        err_cnt = 0;
        pass_cnt = 0;
        fail_cnt = 0;
        drop_cnt = 0;
        wd_cycles = 0;
        void'($urandom(32'h4a8b654a));
        load_patterns();
        repeat (8) @(negedge clk_a);
        rst_n = 1'b1;
        if (n_tests == 0) begin
            $display("no tests were read from the pattern file");
            err_cnt++;
        end else begin
            watch_reset_quiet();
            for (int t = 0; t < n_tests; t++) begin
                drive_test(t);
            end
            @(negedge clk_a);
            in_beat = '0;
            while (exp_q.size() != 0) begin
                @(negedge clk_a);
            end
            // catch any stray frame after the last expected one
            repeat (20) @(negedge clk_a);
            check_count(n_tests - 1, "frames_pending after draining", '0, frames_pending);
        end
        $display("tests run %0d, passed %0d, failed %0d", n_tests, pass_cnt, fail_cnt);
        if (err_cnt == 0 && fail_cnt == 0 && pass_cnt == n_tests) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- dv/frame_buffer_checker.sv
// output protocol assertions, bound into frame_buffer_top for every simulation of it
`timescale 1ns/100ps

module frame_buffer_checker (
    input logic                        clk_a,
    input logic                        rst_n,
    input fb_types_pkg::out_beat_t     out_beat,
    input logic [fb_cfg_pkg::SLOT_W:0] frames_pending,
    input logic                        frame_dropped
);

    last_needs_valid: assert property (
        @(posedge clk_a) disable iff (!rst_n) out_beat.last |-> out_beat.valid
    ) else $error("out_beat.last seen without out_beat.valid");

    pending_in_range: assert property (
        @(posedge clk_a) disable iff (!rst_n) frames_pending <= fb_cfg_pkg::SLOT_COUNT
    ) else $error("frames_pending above slot count");

    // one reset edge is needed before the delay line is known
    quiet_in_reset: assert property (
        @(posedge clk_a) (!rst_n ##1 !rst_n) |-> !out_beat.valid
    ) else $error("out_beat.valid high during reset");

    single_drop_pulse: assert property (
        @(posedge clk_a) disable iff (!rst_n) frame_dropped |=> !frame_dropped
    ) else $error("frame_dropped high on two consecutive cycles");

endmodule

bind frame_buffer_top frame_buffer_checker u_checker (.*);

//--- hdl/frame_buffer_top.sv
// frame buffer top level; the DUT of the testbench, wiring writer, drain side and both RAMs
`timescale 1ns/100ps

module frame_buffer_top (
    input  logic                        clk_a,
    input  logic                        rst_n,
    input  fb_types_pkg::in_beat_t      in_beat,
    input  logic                        drain_en,
    output fb_types_pkg::out_beat_t     out_beat,
    output logic [fb_cfg_pkg::SLOT_W:0] frames_pending,
    output logic                        frame_dropped
);

    localparam int DESC_W = $bits(fb_types_pkg::frame_desc_t);

    fb_types_pkg::ram_wr_t         data_wr;
    fb_types_pkg::ram_wr_t         desc_wr;
    logic                          frame_commit;
    logic                          slots_full;
    logic [fb_cfg_pkg::SLOT_W-1:0] desc_rd_addr;
    logic [fb_cfg_pkg::ADDR_W-1:0] data_rd_addr;
    fb_types_pkg::frame_desc_t     desc_rd_data;
    fb_types_pkg::data_word_t      data_rd_data;
    logic                          cnt_load;
    logic                          cnt_dec;
    logic                          cnt_zero;
    logic [fb_cfg_pkg::LEN_W-1:0]  cnt_load_value;
    logic [fb_cfg_pkg::LEN_W-1:0]  cnt_count;

    frame_writer u_writer (
        .clk_a        (clk_a),
        .rst_n        (rst_n),
        .in_beat      (in_beat),
        .slots_full   (slots_full),
        .data_wr      (data_wr),
        .desc_wr      (desc_wr),
        .frame_commit (frame_commit),
        .frame_dropped(frame_dropped)
    );

    drain_fsm u_drain (
        .clk_a         (clk_a),
        .rst_n         (rst_n),
        .drain_en      (drain_en),
        .frame_commit  (frame_commit),
        .desc_rd_data  (desc_rd_data),
        .data_rd_data  (data_rd_data),
        .count         (cnt_count),
        .zero          (cnt_zero),
        .slots_full    (slots_full),
        .frames_pending(frames_pending),
        .desc_rd_addr  (desc_rd_addr),
        .data_rd_addr  (data_rd_addr),
        .cnt_load      (cnt_load),
        .cnt_load_value(cnt_load_value),
        .cnt_dec       (cnt_dec),
        .out_beat      (out_beat)
    );

    word_counter u_counter (
        .clk_a     (clk_a),
        .rst_n     (rst_n),
        .load      (cnt_load),
        .load_value(cnt_load_value),
        .dec       (cnt_dec),
        .count     (cnt_count),
        .zero      (cnt_zero)
    );

    // port a writes, port b reads
    dp_pipe_ram #(
        .payload_t(fb_types_pkg::data_word_t),
        .ADDR_BITS(fb_cfg_pkg::ADDR_W)
    ) data_ram (
        .clk_a (clk_a),
        .rst_n (rst_n),
        .wr_a  (data_wr.wr),
        .addr_a(data_wr.addr),
        .din_a (data_wr.din),
        .dout_a(),
        .wr_b  (1'b0),
        .addr_b(data_rd_addr),
        .din_b ('0),
        .dout_b(data_rd_data)
    );

    dp_pipe_ram #(
        .payload_t(fb_types_pkg::frame_desc_t),
        .ADDR_BITS(fb_cfg_pkg::SLOT_W)
    ) desc_ram (
        .clk_a (clk_a),
        .rst_n (rst_n),
        .wr_a  (desc_wr.wr),
        .addr_a(desc_wr.addr[fb_cfg_pkg::SLOT_W-1:0]),
        .din_a (fb_types_pkg::frame_desc_t'(desc_wr.din[DESC_W-1:0])),
        .dout_a(),
        .wr_b  (1'b0),
        .addr_b(desc_rd_addr),
        .din_b ('0),
        .dout_b(desc_rd_data)
    );

endmodule

//--- hdl/drain_fsm.sv
// drain side: slot occupancy, descriptor fetch, data read issue and output alignment
`timescale 1ns/100ps

module drain_fsm (
    input  logic                            clk_a,
    input  logic                            rst_n,
    input  logic                            drain_en,
    input  logic                            frame_commit,
    input  fb_types_pkg::frame_desc_t       desc_rd_data,
    input  fb_types_pkg::data_word_t        data_rd_data,
    input  logic [fb_cfg_pkg::LEN_W-1:0]    count,
    input  logic                            zero,
    output logic                            slots_full,
    output logic [fb_cfg_pkg::SLOT_W:0]     frames_pending,
    output logic [fb_cfg_pkg::SLOT_W-1:0]   desc_rd_addr,
    output logic [fb_cfg_pkg::ADDR_W-1:0]   data_rd_addr,
    output logic                            cnt_load,
    output logic [fb_cfg_pkg::LEN_W-1:0]    cnt_load_value,
    output logic                            cnt_dec,
    output fb_types_pkg::out_beat_t         out_beat
);

    localparam int LAT = fb_cfg_pkg::RAM_RD_LATENCY;
    localparam int LW = fb_cfg_pkg::LEN_W;
    localparam int OW = fb_cfg_pkg::OFFS_W;
    localparam int PW = fb_cfg_pkg::SLOT_W + 1;

    typedef enum logic [1:0] {IDLE, DESC_WAIT, ISSUE} state_t;

    state_t                        state;
    state_t                        state_nxt;
    logic [fb_cfg_pkg::SLOT_W-1:0] rd_slot;
    logic [LW-1:0]                 rd_len;
    logic                          rd_trunc;
    logic                          issue;
    logic                          issue_last;
    logic                          frame_done;
    logic [LAT-1:0]                vld_sr;
    logic [LAT-1:0]                last_sr;
    logic [LAT-1:0]                trunc_sr;

    assign issue_last = (count == LW'(1));
    assign frame_done = issue && issue_last;

    always_comb begin
        state_nxt = state;
        cnt_load = 1'b0;
        // counter reaches zero when the descriptor leaves the RAM
        cnt_load_value = LW'(LAT - 1);
        cnt_dec = 1'b0;
        issue = 1'b0;
        case (state)
            IDLE: begin
                // drain_en only matters between frames
                if (frames_pending != '0 && drain_en) begin
                    cnt_load = 1'b1;
                    state_nxt = DESC_WAIT;
                end
            end
            DESC_WAIT: begin
                if (zero) begin
                    cnt_load = 1'b1;
                    cnt_load_value = desc_rd_data.length;
                    state_nxt = ISSUE;
                end else begin
                    cnt_dec = 1'b1;
                end
            end
            ISSUE: begin
                issue = 1'b1;
                cnt_dec = 1'b1;
                if (issue_last) begin
                    state_nxt = IDLE;
                end
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_a) begin
        if (!rst_n) begin
            state          <= IDLE;
            rd_slot        <= '0;
            frames_pending <= '0;
            vld_sr         <= '0;
            last_sr        <= '0;
            trunc_sr       <= '0;
        end else begin
            state <= state_nxt;
            // slot is free again once its last read is issued
            if (frame_done) begin
                rd_slot <= rd_slot + 1'b1;
            end
            frames_pending <= frames_pending + PW'(frame_commit) - PW'(frame_done);
            // flags ride alongside the reads in flight
            vld_sr   <= {vld_sr[LAT-2:0], issue};
            last_sr  <= {last_sr[LAT-2:0], frame_done};
            trunc_sr <= {trunc_sr[LAT-2:0], frame_done && rd_trunc};
        end
    end

    // descriptor of the frame being drained
    always_ff @(posedge clk_a) begin
        if (state == DESC_WAIT && zero) begin
            rd_len   <= desc_rd_data.length;
            rd_trunc <= desc_rd_data.trunc;
        end
    end

    // a commit still in flight counts as occupied
    assign slots_full = (frames_pending == PW'(fb_cfg_pkg::SLOT_COUNT)) ||
                        (frames_pending == PW'(fb_cfg_pkg::SLOT_COUNT - 1) && frame_commit);

    assign desc_rd_addr = rd_slot;
    // offset runs up from 0 while the counter runs down from rd_len
    assign data_rd_addr = {rd_slot, OW'(rd_len - count)};

    assign out_beat.valid = vld_sr[LAT-1];
    assign out_beat.last  = last_sr[LAT-1];
    assign out_beat.trunc = trunc_sr[LAT-1];
    assign out_beat.data  = data_rd_data;

endmodule

//--- hdl/word_counter.sv
// loadable down-counter for the drain side, timing RAM latency and counting data reads
`timescale 1ns/100ps

module word_counter (
    input  logic                         clk_a,
    input  logic                         rst_n,
    input  logic                         load,
    input  logic [fb_cfg_pkg::LEN_W-1:0] load_value,
    input  logic                         dec,
    output logic [fb_cfg_pkg::LEN_W-1:0] count,
    output logic                         zero
);

    // load has priority over dec
    always_ff @(posedge clk_a) begin
        if (!rst_n) begin
            count <= '0;
        end else if (load) begin
            count <= load_value;
        end else if (dec && !zero) begin
            // holds at zero instead of wrapping
            count <= count - 1'b1;
        end
    end

    assign zero = (count == '0);

endmodule

//--- hdl/frame_writer.sv
// input side of the frame buffer: fills slots, truncates, drops when full, writes descriptors
`timescale 1ns/100ps

module frame_writer (
    input  logic                   clk_a,
    input  logic                   rst_n,
    input  fb_types_pkg::in_beat_t in_beat,
    input  logic                   slots_full,
    output fb_types_pkg::ram_wr_t  data_wr,
    output fb_types_pkg::ram_wr_t  desc_wr,
    output logic                   frame_commit,
    output logic                   frame_dropped
);

    localparam int LW = fb_cfg_pkg::LEN_W;
    localparam int OW = fb_cfg_pkg::OFFS_W;
    localparam int DESC_W = $bits(fb_types_pkg::frame_desc_t);

    logic [fb_cfg_pkg::SLOT_W-1:0] wr_slot;
    logic [OW-1:0]                 offset;
    logic                          in_frame;
    logic                          accept;
    // set once the slot is full so that later words are cut
    logic                          sat;

    logic                          first_word;
    logic                          take;
    logic [OW-1:0]                 offs_cur;
    logic                          sat_cur;
    logic                          store;
    logic                          commit;
    fb_types_pkg::frame_desc_t     desc_val;

    always_comb begin
        // accept or drop is decided once, on the first word
        first_word = in_beat.valid && !in_frame;
        take = first_word ? !slots_full : accept;
        offs_cur = first_word ? '0 : offset;
        // slot already holds SLOT_WORDS words
        sat_cur = !first_word && sat;
        store = in_beat.valid && take && !sat_cur;
        commit = in_beat.valid && in_beat.last && take;
        desc_val.trunc = sat_cur;
        desc_val.length = sat_cur ? LW'(fb_cfg_pkg::SLOT_WORDS) : LW'(offs_cur) + 1'b1;
    end

    always_ff @(posedge clk_a) begin
        if (!rst_n) begin
            wr_slot       <= '0;
            offset        <= '0;
            in_frame      <= 1'b0;
            accept        <= 1'b0;
            sat           <= 1'b0;
            frame_commit  <= 1'b0;
            frame_dropped <= 1'b0;
        end else begin
            frame_commit  <= commit;
            frame_dropped <= first_word && slots_full;
            if (in_beat.valid) begin
                in_frame <= !in_beat.last;
                accept   <= take;
                sat      <= sat_cur || (store && offs_cur == OW'(fb_cfg_pkg::SLOT_WORDS - 1));
                offset   <= store ? offs_cur + 1'b1 : offs_cur;
            end
            // slot pointer wraps modulo SLOT_COUNT
            if (commit) begin
                wr_slot <= wr_slot + 1'b1;
            end
        end
    end

    assign data_wr.wr   = store;
    assign data_wr.addr = {wr_slot, offs_cur};
    assign data_wr.din  = in_beat.data;

    assign desc_wr.wr   = commit;
    assign desc_wr.addr = {{(fb_cfg_pkg::ADDR_W - fb_cfg_pkg::SLOT_W){1'b0}}, wr_slot};
    assign desc_wr.din  = {{(fb_cfg_pkg::DATA_W - DESC_W){1'b0}}, desc_val};

endmodule

//--- hdl/dp_pipe_ram.sv
// dual-port RAM with five-stage pipelined ports; instantiate once per payload type
`timescale 1ns/100ps

module dp_pipe_ram #(
    parameter type payload_t = fb_types_pkg::data_word_t,
    parameter int  ADDR_BITS = fb_cfg_pkg::ADDR_W
) (
    input  logic                 clk_a,
    input  logic                 rst_n,
    input  logic                 wr_a,
    input  logic [ADDR_BITS-1:0] addr_a,
    input  payload_t             din_a,
    output payload_t             dout_a,
    input  logic                 wr_b,
    input  logic [ADDR_BITS-1:0] addr_b,
    input  payload_t             din_b,
    output payload_t             dout_b
);

    payload_t mem [0:(1<<ADDR_BITS)-1];

    // index 0 is port a, index 1 is port b
    logic [1:0]           wr_s1;
    logic [1:0]           wr_s2;
    logic [ADDR_BITS-1:0] addr_s1 [2];
    logic [ADDR_BITS-1:0] addr_s2 [2];
    payload_t             din_s1 [2];
    payload_t             din_s2 [2];
    payload_t             rd_s3 [2];
    payload_t             rd_s4 [2];
    payload_t             rd_s5 [2];

    // write enables of both ports, stages 1 and 2
    always_ff @(posedge clk_a) begin
        if (!rst_n) begin
            wr_s1 <= '0;
            wr_s2 <= '0;
        end else begin
            wr_s1 <= {wr_b, wr_a};
            wr_s2 <= wr_s1;
        end
    end

    // request stages 1 and 2
    always_ff @(posedge clk_a) begin
        addr_s1[0] <= addr_a;
        addr_s1[1] <= addr_b;
        din_s1[0]  <= din_a;
        din_s1[1]  <= din_b;
        addr_s2    <= addr_s1;
        din_s2     <= din_s1;
    end

    // stage 3 touches memory and port b wins a same-address write
    // read returns the old word when a write lands on the same edge
    always_ff @(posedge clk_a) begin
        for (int p = 0; p < 2; p++) begin
            if (wr_s2[p]) begin
                mem[addr_s2[p]] <= din_s2[p];
            end
            rd_s3[p] <= mem[addr_s2[p]];
            rd_s4[p] <= rd_s3[p];
            rd_s5[p] <= rd_s4[p];
        end
    end

    assign dout_a = rd_s5[0];
    assign dout_b = rd_s5[1];

endmodule

//--- hdl/fb_types_pkg.sv
// beat, descriptor and RAM request types shared by the frame buffer RTL and testbench
package fb_types_pkg;

    // one payload word
    typedef logic [fb_cfg_pkg::DATA_W-1:0] data_word_t;

    // descriptor RAM entry, one per stored frame
    typedef struct packed {
        logic [fb_cfg_pkg::LEN_W-1:0] length;
        logic                         trunc;
    } frame_desc_t;

    // upstream strobes
    typedef struct packed {
        logic       valid;
        logic       last;
        data_word_t data;
    } in_beat_t;

    // downstream strobes, trunc only qualified by last
    typedef struct packed {
        logic       valid;
        logic       last;
        logic       trunc;
        data_word_t data;
    } out_beat_t;

    // write request into either RAM
    // descriptor writes use the low bits of addr and din
    typedef struct packed {
        logic                          wr;
        logic [fb_cfg_pkg::ADDR_W-1:0] addr;
        data_word_t                    din;
    } ram_wr_t;

endpackage

//--- hdl/fb_cfg_pkg.sv
// sizing and pipeline timing constants for the frame buffer, referenced by scoped name
package fb_cfg_pkg;

    // payload word width
    localparam int DATA_W = 16;

    // slot ring
    localparam int SLOT_COUNT = 8;
    localparam int SLOT_W = 3;

    // words per slot, longer frames get cut here
    localparam int SLOT_WORDS = 32;
    localparam int OFFS_W = 5;

    // data RAM address is slot index above word offset
    localparam int ADDR_W = SLOT_W + OFFS_W;

    // stored length holds 1 to SLOT_WORDS
    localparam int LEN_W = 6;

    // read address to read data, both RAM ports
    localparam int RAM_RD_LATENCY = 5;

endpackage
